//--- common/fabric_pkg.sv
`default_nettype none

package fabric_pkg;

        // Aperture field sits in the upper address bits
        localparam int APER_MSB      = 16;
        localparam int APER_LSB      = 12;
        // Byte offset width inside one aperture
        localparam int REG_OFS_WIDTH = 10;

        // One host access, held steady until ack
        typedef struct packed {
                logic [APER_MSB:0] adr;
                logic              cyc;
                logic              stb;
                logic              we;
                logic [3:0]        byte_stb;
                logic [31:0]       wr_dat;
        } wb_req_t;

        // One slave answer
        typedef struct packed {
                logic [31:0] rd_dat;
                logic        ack;
        } wb_rsp_t;

        // One-hot aperture select
        typedef struct packed {
                logic resv;
                logic regs;
        } aperture_sel_t;

        // Aperture base addresses, 4 KB each
        localparam logic [APER_MSB:0] FPGA_REG_BASE    = 17'h00000;
        localparam logic [APER_MSB:0] QL_RESERVED_BASE = 17'h05000;

        // Fabric register byte offsets
        localparam logic [REG_OFS_WIDTH-1:0] FPGA_REG_ID_ADR  = 10'h000;
        localparam logic [REG_OFS_WIDTH-1:0] FPGA_REV_NUM_ADR = 10'h004;
        localparam logic [REG_OFS_WIDTH-1:0] FPGA_SCRATCH_ADR = 10'h008;

        // Fabric register values
        localparam logic [31:0] DEVICE_ID          = 32'hABCD0200;
        localparam logic [31:0] REV_LEVEL          = 32'h00000100;
        localparam logic [31:0] SCRATCH_RESET      = 32'h12345678;
        // Marks a read of an undefined fabric offset
        localparam logic [31:0] FAB_DEF_REG_VALUE  = 32'hFABDEFAC;
        // Bad fabric access, unmapped aperture
        localparam logic [31:0] DEFAULT_READ_VALUE = 32'hBADFABAC;

        // Reserved block offsets
        localparam logic [REG_OFS_WIDTH-1:0] QL_RESERVED_CUST_PROD_ADR = 10'h1F8;
        localparam logic [REG_OFS_WIDTH-1:0] QL_RESERVED_REVISIONS_ADR = 10'h1FC;

        // Identification fields
        localparam logic [7:0]  CUSTOMER_ID      = 8'h01;
        localparam logic [7:0]  PRODUCT_ID       = 8'h00;
        localparam logic [15:0] MAJOR_REV        = 16'h0001;
        localparam logic [15:0] MINOR_REV        = 16'h0000;
        // Marks a read of an undefined reserved offset
        localparam logic [31:0] QL_DEF_REG_VALUE = 32'hDEFFABAC;

        // Bus timeout counter
        localparam int                            DEFAULT_CNTR_WIDTH   = 3;
        localparam logic [DEFAULT_CNTR_WIDTH-1:0] DEFAULT_CNTR_TIMEOUT = 3'd7;

        // Reference clock divider, modulo 12
        localparam logic [3:0] REF_DIV_TERMINAL = 4'd11;
        localparam logic [3:0] REF_DIV_TOGGLE   = 4'd5;

endpackage

`default_nettype wire

//--- fabric_regs/fabric_regs.sv
`default_nettype none

module fabric_regs (
        input  logic                bitclk_local,
        input  logic                RST_IP_i,
        input  fabric_pkg::wb_req_t wb_req_i,
        input  logic                sel_i,
        output fabric_pkg::wb_rsp_t wb_rsp_o
);

        logic                                 ack_q;
        logic [31:0]                          scratch_q;
        logic                                 scratch_wr;
        // Word-aligned byte offset inside the aperture
        logic [fabric_pkg::REG_OFS_WIDTH-1:0] ofs;

        // Low two bits ignored, registers are whole words
        assign ofs = {wb_req_i.adr[fabric_pkg::REG_OFS_WIDTH-1:2], 2'b00};

        // Single-cycle ack, one clock after select and stb are seen
        always_ff @(posedge bitclk_local or posedge RST_IP_i) begin
                if (RST_IP_i) begin
                        ack_q <= 1'b0;
                end else begin
                        // Blocked while ack is up, host still holds stb then
                        ack_q <= sel_i && wb_req_i.stb && !ack_q;
                end
        end

        // Write lands on the edge where ack is high
        assign scratch_wr = ack_q && sel_i && wb_req_i.we &&
                            (ofs == fabric_pkg::FPGA_SCRATCH_ADR);

        // Scratch register, byte-lane writes
        always_ff @(posedge bitclk_local or posedge RST_IP_i) begin
                if (RST_IP_i) begin
                        scratch_q <= fabric_pkg::SCRATCH_RESET;
                end else if (scratch_wr) begin
                        for (int b = 0; b < 4; b++) begin
                                if (wb_req_i.byte_stb[b]) begin
                                        scratch_q[8*b +: 8] <= wb_req_i.wr_dat[8*b +: 8];
                                end
                        end
                end
        end

        // Read data valid while ack is high
        always_comb begin
                case (ofs)
                        fabric_pkg::FPGA_REG_ID_ADR: begin
                                wb_rsp_o.rd_dat = fabric_pkg::DEVICE_ID;
                        end
                        fabric_pkg::FPGA_REV_NUM_ADR: begin
                                wb_rsp_o.rd_dat = fabric_pkg::REV_LEVEL;
                        end
                        fabric_pkg::FPGA_SCRATCH_ADR: begin
                                wb_rsp_o.rd_dat = scratch_q;
                        end
                        default: begin
                                // Undefined offset marker
                                wb_rsp_o.rd_dat = fabric_pkg::FAB_DEF_REG_VALUE;
                        end
                endcase
        end

        assign wb_rsp_o.ack = ack_q;

        // Ack is a one-cycle pulse
        ack_pulse: assert property (
                @(posedge bitclk_local) disable iff (RST_IP_i)
                ack_q |=> !ack_q
        ) else $error("fabric_regs ack high for two cycles");

endmodule

`default_nettype wire

//--- ql_reserved/ql_reserved.sv
`default_nettype none

module ql_reserved (
        input  logic                bitclk_local,
        input  logic                RST_IP_i,
        input  fabric_pkg::wb_req_t wb_req_i,
        input  logic                sel_i,
        input  logic                bus_ack_i,
        output fabric_pkg::wb_rsp_t wb_rsp_o
);

        logic [fabric_pkg::DEFAULT_CNTR_WIDTH-1:0] tmo_cnt_q;
        logic                                      ack_q;
        // Access open with nobody answering yet
        logic                                      bus_busy;
        logic                                      tmo_hit;
        logic [fabric_pkg::REG_OFS_WIDTH-1:0]      ofs;

        assign ofs      = {wb_req_i.adr[fabric_pkg::REG_OFS_WIDTH-1:2], 2'b00};
        assign bus_busy = wb_req_i.cyc && wb_req_i.stb && !bus_ack_i;
        assign tmo_hit  = (tmo_cnt_q == fabric_pkg::DEFAULT_CNTR_TIMEOUT);

        // Timeout counter, counts unanswered cycles of any aperture
        always_ff @(posedge bitclk_local or posedge RST_IP_i) begin
                if (RST_IP_i) begin
                        tmo_cnt_q <= '0;
                end else if (!bus_busy || tmo_hit) begin
                        // Restart on any ack, idle bus, or after firing
                        tmo_cnt_q <= '0;
                end else begin
                        tmo_cnt_q <= tmo_cnt_q + 1'b1;
                end
        end

        // Own registers ack like fabric_regs
        // Timeout ack follows the cycle the count hits the limit
        always_ff @(posedge bitclk_local or posedge RST_IP_i) begin
                if (RST_IP_i) begin
                        ack_q <= 1'b0;
                end else begin
                        ack_q <= !ack_q &&
                                 ((sel_i && wb_req_i.stb) || (bus_busy && tmo_hit));
                end
        end

        // Identification words
        always_comb begin
                case (ofs)
                        fabric_pkg::QL_RESERVED_CUST_PROD_ADR: begin
                                wb_rsp_o.rd_dat = {16'h0000, fabric_pkg::CUSTOMER_ID,
                                                   fabric_pkg::PRODUCT_ID};
                        end
                        fabric_pkg::QL_RESERVED_REVISIONS_ADR: begin
                                wb_rsp_o.rd_dat = {fabric_pkg::MAJOR_REV,
                                                   fabric_pkg::MINOR_REV};
                        end
                        default: begin
                                wb_rsp_o.rd_dat = fabric_pkg::QL_DEF_REG_VALUE;
                        end
                endcase
        end

        assign wb_rsp_o.ack = ack_q;

        // Counter must wrap before passing the limit
        cnt_limit: assert property (
                @(posedge bitclk_local) disable iff (RST_IP_i)
                tmo_cnt_q <= fabric_pkg::DEFAULT_CNTR_TIMEOUT
        ) else $error("timeout count past limit: %0d", tmo_cnt_q);

        // No ack outside an open access
        ack_in_access: assert property (
                @(posedge bitclk_local) disable iff (RST_IP_i)
                ack_q |-> (wb_req_i.cyc && wb_req_i.stb)
        ) else $error("ql_reserved ack without cyc and stb");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert \
        --top-module fabric_tb \
        -f verilog.f \
        --Mdir obj_dir -o fabric_sim \
        && ./obj_dir/fabric_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^Done: no errors$" sim.log 2>/dev/null \
        && echo "simulation passed" \
        || { echo "simulation failed"; exit 1; }

//--- test/fabric_tb.sv
`default_nettype none

module fabric_tb;

        localparam int CLK_PERIOD   = 40;
        localparam int RESET_CYCLES = 16;
        localparam int NUM_TESTS    = 5;
        // Longest wait for a bus ack
        localparam int ACK_CAP      = 20;

        logic                bitclk_local;
        logic                rst_ip;
        fabric_pkg::wb_req_t req;
        fabric_pkg::wb_rsp_t rsp;
        logic                ref_clk;
        int                  seed;
        // Shadow of the scratch register
        logic [31:0]         scratch_model;

        fabric_top DUT (
                .bitclk_local (bitclk_local),
                .RST_IP_i     (rst_ip),
                .wb_req_i     (req),
                .wb_rsp_o     (rsp),
                .ref_clk_o    (ref_clk)
        );

        initial begin
                bitclk_local = 1'b0;
                forever #(CLK_PERIOD / 2) bitclk_local = ~bitclk_local;
        end

        // Watchdog, scaled by the number of tests
        initial begin
                #(CLK_PERIOD * (NUM_TESTS * 400 + 2000));
                $display("watchdog expired before the tests finished");
                $display("Done: errors found");
                $fatal(1, "simulation timeout");
        end

        task automatic check_word(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                if (actual !== expected) begin
                        $display("mismatch %s: expected %08h, actual %08h", name, expected, actual);
                        $display("Done: errors found");
                        $fatal(1, "word check failed");
                end
        endtask

        task automatic check_period(input string name, input int expected, input int actual);
                if (actual != expected) begin
                        $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
                        $display("Done: errors found");
                        $fatal(1, "cycle count check failed");
                end
        endtask

        task automatic check_level(input string name, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("mismatch %s: expected %b, actual %b", name, expected, actual);
                        $display("Done: errors found");
                        $fatal(1, "level check failed");
                end
        endtask

        task automatic fail_no_ack(input logic [16:0] adr);
                $display("bus access to %05h got no ack within %0d cycles", adr, ACK_CAP);
                $display("Done: errors found");
                $fatal(1, "missing ack");
        endtask

        // One access; latency counts rising edges from stb to ack
        task automatic wb_access(input logic we, input logic [16:0] adr, input logic [3:0] be,
                                 input logic [31:0] dat, output logic [31:0] rdat,
                                 output int latency);
                int   n;
                logic seen;
                n    = 0;
                seen = 1'b0;
                rdat = '0;
                @(posedge bitclk_local);
                req.adr      <= adr;
                req.cyc      <= 1'b1;
                req.stb      <= 1'b1;
                req.we       <= we;
                req.byte_stb <= be;
                req.wr_dat   <= dat;
                while (!seen && n < ACK_CAP) begin
                        @(posedge bitclk_local);
                        n++;
                        // Ack and data are stable mid cycle
                        @(negedge bitclk_local);
                        if (rsp.ack) begin
                                seen = 1'b1;
                                rdat = rsp.rd_dat;
                        end
                end
                if (!seen) begin
                        fail_no_ack(adr);
                end
                latency = n;
                // Drop the request at the edge that takes the ack
                @(posedge bitclk_local);
                req.cyc <= 1'b0;
                req.stb <= 1'b0;
                req.we  <= 1'b0;
                @(posedge bitclk_local);
        endtask

        task automatic wb_write(input logic [16:0] adr, input logic [3:0] be,
                                input logic [31:0] dat, output int latency);
                logic [31:0] unused;
                wb_access(1'b1, adr, be, dat, unused, latency);
        endtask

        task automatic wb_read(input logic [16:0] adr, output logic [31:0] dat,
                               output int latency);
                wb_access(1'b0, adr, 4'h0, 32'h0, dat, latency);
        endtask

        // Read one address, compare data and ack latency
        task automatic read_expect(input string name, input logic [16:0] adr,
                                   input logic [31:0] expected, input int exp_latency);
                logic [31:0] dat;
                int          lat;
                wb_read(adr, dat, lat);
                check_word(name, expected, dat);
                check_period({name, " latency"}, exp_latency, lat);
        endtask

        task automatic id_regs_read();
                read_expect("device id", 17'h00000, fabric_pkg::DEVICE_ID, 1);
                read_expect("revision", 17'h00004, fabric_pkg::REV_LEVEL, 1);
        endtask

        task automatic scratch_rw();
                logic [31:0] dat;
                logic [31:0] expected;
                int          lat;
                read_expect("scratch reset", 17'h00008, fabric_pkg::SCRATCH_RESET, 1);
                scratch_model = fabric_pkg::SCRATCH_RESET;
                repeat (4) begin
                        dat = $random(seed);
                        wb_write(17'h00008, 4'hF, dat, lat);
                        check_period("scratch write latency", 1, lat);
                        scratch_model = dat;
                        read_expect("scratch full word", 17'h00008, scratch_model, 1);
                end
                // Lanes 0 and 2 only
                dat = $random(seed);
                wb_write(17'h00008, 4'b0101, dat, lat);
                expected = {scratch_model[31:24], dat[23:16], scratch_model[15:8], dat[7:0]};
                scratch_model = expected;
                read_expect("scratch byte lanes", 17'h00008, expected, 1);
        endtask

        task automatic undefined_offsets();
                read_expect("fabric undefined", 17'h0000C, fabric_pkg::FAB_DEF_REG_VALUE, 1);
                read_expect("fabric top offset", 17'h003FC, fabric_pkg::FAB_DEF_REG_VALUE, 1);
                // Customer in bits 15:8, product in bits 7:0
                read_expect("customer product", 17'h051F8, 32'h0000_0100, 1);
                // Major in the upper half, minor in the lower
                read_expect("revisions", 17'h051FC, 32'h0001_0000, 1);
                read_expect("reserved undefined", 17'h05010, fabric_pkg::QL_DEF_REG_VALUE, 1);
        endtask

        task automatic unmapped_timeout();
                logic [31:0] dat;
                int          lat;
                read_expect("unmapped read", 17'h03000, fabric_pkg::DEFAULT_READ_VALUE, 8);
                // Same low offset as scratch, other aperture
                dat = $random(seed);
                wb_write(17'h03008, 4'hF, dat, lat);
                check_period("unmapped write latency", 8, lat);
                read_expect("scratch after unmapped", 17'h00008, scratch_model, 1);
        endtask

        // Count falling bitclk edges until ref_clk changes
        task automatic wait_ref_toggle(output int cycles);
                logic start;
                start  = ref_clk;
                cycles = 0;
                do begin
                        @(negedge bitclk_local);
                        cycles++;
                end while (ref_clk == start && cycles < 40);
                if (ref_clk == start) begin
                        $display("reference clock stopped toggling");
                        $display("Done: errors found");
                        $fatal(1, "reference clock stuck");
                end
        endtask

        task automatic ref_clk_timing();
                int skip;
                int high_len;
                int low_len;
                int period_len;
                // Align on a rising edge
                if (ref_clk) begin
                        wait_ref_toggle(skip);
                end
                wait_ref_toggle(skip);
                repeat (2) begin
                        wait_ref_toggle(high_len);
                        wait_ref_toggle(low_len);
                        check_period("ref clk high time", 6, high_len);
                        check_period("ref clk low time", 6, low_len);
                end
                // Next full period, rising edge to rising edge
                wait_ref_toggle(high_len);
                wait_ref_toggle(low_len);
                period_len = high_len + low_len;
                check_period("ref clk period", 12, period_len);
        endtask

        initial begin
                seed          = 42375;
                scratch_model = '0;
                rst_ip        = 1'b1;
                req           = '0;
                repeat (RESET_CYCLES) @(posedge bitclk_local);
                rst_ip <= 1'b0;
                @(negedge bitclk_local);
                check_level("ref clk after reset", 1'b0, ref_clk);
                id_regs_read();
                scratch_rw();
                undefined_offsets();
                unmapped_timeout();
                ref_clk_timing();
                $display("Done: no errors");
                $finish;
        end

endmodule

`default_nettype wire

//--- verilog.f
common/fabric_pkg.sv
verilog/wb_aperture_decode.sv
verilog/ref_clk_div12.sv
fabric_regs/fabric_regs.sv
ql_reserved/ql_reserved.sv
verilog/fabric_top.sv
test/fabric_tb.sv

//--- verilog/fabric_top.sv
`default_nettype none

module fabric_top (
        input  logic                bitclk_local,
        input  logic                RST_IP_i,
        input  fabric_pkg::wb_req_t wb_req_i,
        output fabric_pkg::wb_rsp_t wb_rsp_o,
        output logic                ref_clk_o
);

        // Aperture selects from the decoder
        fabric_pkg::aperture_sel_t sel;
        // Slave answers into the read mux
        fabric_pkg::wb_rsp_t       regs_rsp;
        fabric_pkg::wb_rsp_t       resv_rsp;

        wb_aperture_decode u_decode (
                .wb_req_i   (wb_req_i),
                .sel_o      (sel),
                .regs_rsp_i (regs_rsp),
                .resv_rsp_i (resv_rsp),
                .wb_rsp_o   (wb_rsp_o)
        );

        // Device ID, revision, scratch
        fabric_regs u_fabric_regs (
                .bitclk_local (bitclk_local),
                .RST_IP_i     (RST_IP_i),
                .wb_req_i     (wb_req_i),
                .sel_i        (sel.regs),
                .wb_rsp_o     (regs_rsp)
        );

        // Sees the combined ack to run the bus timeout
        ql_reserved u_ql_reserved (
                .bitclk_local (bitclk_local),
                .RST_IP_i     (RST_IP_i),
                .wb_req_i     (wb_req_i),
                .sel_i        (sel.resv),
                .bus_ack_i    (wb_rsp_o.ack),
                .wb_rsp_o     (resv_rsp)
        );

        // Reference clock, bitclk_local / 12
        ref_clk_div12 u_ref_clk_div12 (
                .bitclk_local (bitclk_local),
                .RST_IP_i     (RST_IP_i),
                .ref_clk_o    (ref_clk_o)
        );

endmodule

`default_nettype wire

//--- verilog/ref_clk_div12.sv
`default_nettype none

module ref_clk_div12 (
        input  logic bitclk_local,
        input  logic RST_IP_i,
        output logic ref_clk_o
);

        // Modulo-12 count and toggle flop
        logic [3:0] cnt_q;
        logic       clk_q;

        // 0 1 2 3 4 5 6 7 8 9 A B  count
        // 0 0 0 0 0 0 1 1 1 1 1 1  output
        always_ff @(posedge bitclk_local or posedge RST_IP_i) begin
                if (RST_IP_i) begin
                        cnt_q <= 4'd0;
                        clk_q <= 1'b0;
                end else begin
                        // Wrap after the last count
                        if (cnt_q == fabric_pkg::REF_DIV_TERMINAL) begin
                                cnt_q <= 4'd0;
                        end else begin
                                cnt_q <= cnt_q + 4'd1;
                        end

                        // Toggle at mid period and at wrap, 50% duty
                        if (cnt_q == fabric_pkg::REF_DIV_TOGGLE ||
                            cnt_q == fabric_pkg::REF_DIV_TERMINAL) begin
                                clk_q <= !clk_q;
                        end
                end
        end

        assign ref_clk_o = clk_q;

        // Count stays inside the modulo range
        cnt_in_range: assert property (
                @(posedge bitclk_local) disable iff (RST_IP_i)
                cnt_q <= fabric_pkg::REF_DIV_TERMINAL
        ) else $error("reference divider count out of range: %0d", cnt_q);

endmodule

`default_nettype wire

//--- verilog/wb_aperture_decode.sv
`default_nettype none

module wb_aperture_decode (
        input  fabric_pkg::wb_req_t       wb_req_i,
        output fabric_pkg::aperture_sel_t sel_o,
        input  fabric_pkg::wb_rsp_t       regs_rsp_i,
        input  fabric_pkg::wb_rsp_t       resv_rsp_i,
        output fabric_pkg::wb_rsp_t       wb_rsp_o
);

        // Aperture field of the current address
        logic [fabric_pkg::APER_MSB-fabric_pkg::APER_LSB:0] aper;
        logic                                               regs_hit;
        logic                                               resv_hit;

        assign aper = wb_req_i.adr[fabric_pkg::APER_MSB:fabric_pkg::APER_LSB];

        // Field compare against each base
        assign regs_hit = (aper ==
                fabric_pkg::FPGA_REG_BASE[fabric_pkg::APER_MSB:fabric_pkg::APER_LSB]);
        assign resv_hit = (aper ==
                fabric_pkg::QL_RESERVED_BASE[fabric_pkg::APER_MSB:fabric_pkg::APER_LSB]);

        // Chip selects only while a cycle is open
        assign sel_o.regs = regs_hit && wb_req_i.cyc;
        assign sel_o.resv = resv_hit && wb_req_i.cyc;

        // Any slave may answer, including the timeout path in ql_reserved
        assign wb_rsp_o.ack = regs_rsp_i.ack || resv_rsp_i.ack;

        // Read data by aperture field
        always_comb begin
                if (regs_hit) begin
                        wb_rsp_o.rd_dat = regs_rsp_i.rd_dat;
                end else if (resv_hit) begin
                        wb_rsp_o.rd_dat = resv_rsp_i.rd_dat;
                end else begin
                        // Unmapped aperture, only the timeout acks this
                        wb_rsp_o.rd_dat = fabric_pkg::DEFAULT_READ_VALUE;
                end
        end

        // Two apertures must never be claimed at once
        always_comb begin
                sel_onehot: assert final ($onehot0(sel_o))
                        else $error("aperture select not one-hot: %b", sel_o);
        end

endmodule

`default_nettype wire
